// ==== logic/priv_pkg.sv ====
package priv_pkg;

    localparam int uop_w = 5;

    // bit positions inside the one-hot micro-op type
    localparam int uop_csr   = 0;
    localparam int uop_cache = 1;
    localparam int uop_ertn  = 2;
    localparam int uop_idle  = 3;
    localparam int uop_tlb   = 4;

    // tlb sub-op, ins[11:10]
    localparam logic [1:0] tlb_srch = 2'b10;
    localparam logic [1:0] tlb_rd   = 2'b11;
    localparam logic [1:0] tlb_wr   = 2'b00;
    localparam logic [1:0] tlb_fill = 2'b01;

    localparam int invtlb_bit = 16;          // ins bit that marks invtlb

    // cacop target, ins[2:0]
    localparam logic [2:0] cacop_tgt_i = 3'b000;
    localparam logic [2:0] cacop_tgt_d = 3'b001;

    typedef enum logic [2:0] {
        st_init,
        st_csr,
        st_cacop,
        st_idle_wait,
        st_idle_blk,
        st_tlb,
        st_done
    } priv_state_t;

endpackage

// ==== logic/csr_pkg.sv ====
package csr_pkg;

    localparam int csr_addr_w = 14;

    // csr numbers
    localparam logic [csr_addr_w-1:0] csr_crmd  = 14'h000;
    localparam logic [csr_addr_w-1:0] csr_prmd  = 14'h001;
    localparam logic [csr_addr_w-1:0] csr_era   = 14'h006;
    localparam logic [csr_addr_w-1:0] csr_save0 = 14'h030;
    localparam logic [csr_addr_w-1:0] csr_save1 = 14'h031;
    localparam logic [csr_addr_w-1:0] csr_save2 = 14'h032;
    localparam logic [csr_addr_w-1:0] csr_save3 = 14'h033;

    // writable bits: plv in 1:0, ie in 2
    localparam logic [31:0] crmd_mask = 32'h0000_0007;
    localparam logic [31:0] prmd_mask = 32'h0000_0007;

endpackage

// ==== logic/csr_bus_if.sv ====
`timescale 1ns/1ps
interface csr_bus_if;

    logic [csr_pkg::csr_addr_w-1:0] addr;
    logic [31:0]                    wdata;
    logic                           wen;
    logic                           ren;
    logic [31:0]                    rdata;   // comb from addr

    modport ctrl (
        output addr,
        output wdata,
        output wen,
        output ren,
        input  rdata
    );

    modport file (
        input  addr,
        input  wdata,
        input  wen,
        input  ren,
        output rdata
    );

endinterface

// ==== logic/priv_ctrl.sv ====
`timescale 1ns/1ps
module priv_ctrl (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       en,
    input  logic [31:0]                ins,
    input  logic [31:0]                rj_data,
    input  logic [31:0]                rk_data,
    input  logic [priv_pkg::uop_w-1:0] uop,
    output logic                       done,
    output logic [31:0]                rd_value,
    csr_bus_if.ctrl                    csr,
    output logic                       ertn_en,
    output logic                       cacop_start,
    output logic                       cacop_dcache,
    input  logic                       cacop_finish,
    input  logic                       i_idle,
    input  logic                       d_idle,
    output logic                       block_cache,
    output logic                       block_clock,
    output logic                       tlbsrch_valid,
    output logic                       tlbrd_valid,
    output logic                       tlbwr_valid,
    output logic                       tlbfill_valid,
    output logic                       invtlb_valid,
    input  logic                       tlbsrch_ready,
    input  logic                       tlbrd_ready,
    input  logic                       tlbwr_ready,
    input  logic                       tlbfill_ready,
    input  logic                       invtlb_ready
);

    priv_pkg::priv_state_t state;
    priv_pkg::priv_state_t next_state;

    logic                           is_icache;
    logic                           is_dcache;
    logic                           dec_csr;
    logic                           dec_cache;
    logic                           dec_ertn;
    logic                           dec_idle;
    logic [4:0]                     tlb_sel;     // inv fill wr rd srch
    logic [4:0]                     dec_tlb;
    logic [4:0]                     tlb_sel_q;
    logic [4:0]                     tlb_ready;
    logic                           known;
    logic                           start;
    logic [csr_pkg::csr_addr_w-1:0] csr_addr_q;
    logic                           csr_we_q;
    logic                           csr_xchg_q;
    logic [31:0]                    csr_mask_q;
    logic [31:0]                    csr_rk_q;

    assign is_icache = uop[priv_pkg::uop_cache] && (ins[2:0] == priv_pkg::cacop_tgt_i);
    assign is_dcache = uop[priv_pkg::uop_cache] && (ins[2:0] == priv_pkg::cacop_tgt_d);
    assign tlb_ready = {invtlb_ready, tlbfill_ready, tlbwr_ready, tlbrd_ready, tlbsrch_ready};
    assign start     = en && (state == priv_pkg::st_init);

    // invtlb carries rk in bits 14:10, so its marker bit is tested before the sub-op
    always_comb
    begin
        tlb_sel = 5'b00000;
        if (ins[priv_pkg::invtlb_bit])
            tlb_sel = 5'b10000;
        else
            case (ins[11:10])
                priv_pkg::tlb_srch: tlb_sel = 5'b00001;
                priv_pkg::tlb_rd:   tlb_sel = 5'b00010;
                priv_pkg::tlb_wr:   tlb_sel = 5'b00100;
                priv_pkg::tlb_fill: tlb_sel = 5'b01000;
                default:            tlb_sel = 5'b00000;
            endcase
    end

    always_comb
    begin
        dec_csr   = 1'b0;
        dec_cache = 1'b0;
        dec_ertn  = 1'b0;
        dec_idle  = 1'b0;
        dec_tlb   = 5'b00000;
        if (uop[priv_pkg::uop_csr])
            dec_csr = 1'b1;
        else if (is_icache || is_dcache)
            dec_cache = 1'b1;
        else if (uop[priv_pkg::uop_ertn])
            dec_ertn = 1'b1;
        else if (uop[priv_pkg::uop_idle])
            dec_idle = 1'b1;
        else if (uop[priv_pkg::uop_tlb])
            dec_tlb = tlb_sel;
    end

    assign known = dec_csr || dec_cache || dec_ertn || dec_idle || (|dec_tlb);

    always_comb
    begin
        next_state = state;
        case (state)
            priv_pkg::st_init:
            begin
                if (start && dec_csr)
                    next_state = priv_pkg::st_csr;
                else if (start && dec_cache)
                    next_state = priv_pkg::st_cacop;
                else if (start && dec_ertn)
                    next_state = priv_pkg::st_done;
                else if (start && dec_idle)
                    next_state = priv_pkg::st_idle_wait;
                else if (start && (|dec_tlb))
                    next_state = priv_pkg::st_tlb;
            end
            priv_pkg::st_csr:       next_state = priv_pkg::st_init;
            priv_pkg::st_cacop:
            begin
                if (cacop_finish)
                    next_state = priv_pkg::st_done;
            end
            priv_pkg::st_idle_wait:
            begin
                if (i_idle && d_idle)
                    next_state = priv_pkg::st_idle_blk;
            end
            priv_pkg::st_idle_blk:  next_state = priv_pkg::st_done;
            priv_pkg::st_tlb:
            begin
                if (|(tlb_sel_q & tlb_ready))
                    next_state = priv_pkg::st_done;
            end
            default:                next_state = priv_pkg::st_init;
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state     <= priv_pkg::st_init;
            done      <= 1'b0;
            tlb_sel_q <= 5'b00000;
        end
        else
        begin
            state <= next_state;
            done  <= (next_state == priv_pkg::st_csr) || (next_state == priv_pkg::st_done);
            if (start)
                tlb_sel_q <= dec_tlb;
        end
    end

    // csr operands held for the write cycle
    always_ff @(posedge clk)
    begin
        if (start && dec_csr)
        begin
            rd_value   <= csr.rdata;              // old value
            csr_addr_q <= ins[23:10];
            csr_we_q   <= |ins[9:5];              // rj != 0
            csr_xchg_q <= |ins[9:6];              // rj > 1
            csr_mask_q <= rj_data;
            csr_rk_q   <= rk_data;
        end
    end

    assign csr.addr  = (state == priv_pkg::st_csr) ? csr_addr_q : ins[23:10];
    assign csr.ren   = (start && dec_csr) || (state == priv_pkg::st_csr);
    assign csr.wen   = (state == priv_pkg::st_csr) && csr_we_q;
    assign csr.wdata = csr_xchg_q ? ((rd_value & ~csr_mask_q) | (csr_rk_q & csr_mask_q))
                                  : csr_rk_q;

    assign ertn_en      = start && dec_ertn;
    assign cacop_start  = start && dec_cache;
    assign cacop_dcache = is_dcache;
    assign block_cache  = (start && dec_idle) || (state == priv_pkg::st_idle_wait)
                          || (state == priv_pkg::st_idle_blk);
    assign block_clock  = (state == priv_pkg::st_idle_blk);

    assign tlbsrch_valid = start && dec_tlb[0];
    assign tlbrd_valid   = start && dec_tlb[1];
    assign tlbwr_valid   = start && dec_tlb[2];
    assign tlbfill_valid = start && dec_tlb[3];
    assign invtlb_valid  = start && dec_tlb[4];

    a_en_idle: assert property (@(posedge clk) disable iff (!rstn)
        en |-> state == priv_pkg::st_init);
    a_en_known: assert property (@(posedge clk) disable iff (!rstn)
        en |-> known);
    a_tlb_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0({tlbsrch_valid, tlbrd_valid, tlbwr_valid, tlbfill_valid, invtlb_valid}));

endmodule

// ==== logic/csr_file.sv ====
`timescale 1ns/1ps
module csr_file (
    input  logic        clk,
    input  logic        rstn,
    csr_bus_if.file     csr,
    input  logic        ertn_en,
    output logic [31:0] ertn_pc,
    output logic [1:0]  plv
);

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] era;
    logic [31:0] save [4];

    always_comb
    begin
        case (csr.addr)
            csr_pkg::csr_crmd:  csr.rdata = crmd;
            csr_pkg::csr_prmd:  csr.rdata = prmd;
            csr_pkg::csr_era:   csr.rdata = era;
            csr_pkg::csr_save0: csr.rdata = save[0];
            csr_pkg::csr_save1: csr.rdata = save[1];
            csr_pkg::csr_save2: csr.rdata = save[2];
            csr_pkg::csr_save3: csr.rdata = save[3];
            default:            csr.rdata = 32'h0;    // unknown csr
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            crmd <= 32'h0;
            prmd <= 32'h0;
            era  <= 32'h0;
            save <= '{default: 32'h0};
        end
        else if (ertn_en)
            crmd[2:0] <= prmd[2:0];               // restore plv and ie
        else if (csr.wen)
        begin
            case (csr.addr)
                csr_pkg::csr_crmd:  crmd    <= csr.wdata & csr_pkg::crmd_mask;
                csr_pkg::csr_prmd:  prmd    <= csr.wdata & csr_pkg::prmd_mask;
                csr_pkg::csr_era:   era     <= csr.wdata;
                csr_pkg::csr_save0: save[0] <= csr.wdata;
                csr_pkg::csr_save1: save[1] <= csr.wdata;
                csr_pkg::csr_save2: save[2] <= csr.wdata;
                csr_pkg::csr_save3: save[3] <= csr.wdata;
                default: ;
            endcase
        end
    end

    assign ertn_pc = era;
    assign plv     = crmd[1:0];

    a_wen_ren: assert property (@(posedge clk) disable iff (!rstn)
        csr.wen |-> csr.ren);

endmodule

// ==== logic/cacop_port.sv ====
`timescale 1ns/1ps
module cacop_port (
    input  logic        clk,
    input  logic        rstn,
    input  logic        cacop_start,
    input  logic        cacop_dcache,
    input  logic [31:0] ins,
    input  logic [31:0] rj_data,
    output logic        cacop_finish,
    output logic [1:0]  cacop_ins_type,
    output logic [31:0] cacop_vaddr,
    output logic        cacop_i_en,
    output logic        cacop_d_en,
    input  logic        cacop_i_ready,
    input  logic        cacop_d_ready,
    input  logic        cacop_i_done,
    input  logic        cacop_d_done
);

    logic        dsel_q;                          // target is dcache
    logic        wait_q;                          // request accepted, awaiting done
    logic [31:0] imm_ext;
    logic        ready_hit;
    logic        done_hit;

    assign imm_ext      = {{20{ins[21]}}, ins[21:10]};
    assign ready_hit    = dsel_q ? cacop_d_ready : cacop_i_ready;
    assign done_hit     = dsel_q ? cacop_d_done : cacop_i_done;
    assign cacop_finish = wait_q && done_hit;

    always_ff @(posedge clk)
    begin
        if (cacop_start)
        begin
            cacop_ins_type <= ins[4:3];
            cacop_vaddr    <= rj_data + imm_ext;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            dsel_q     <= 1'b0;
            wait_q     <= 1'b0;
            cacop_i_en <= 1'b0;
            cacop_d_en <= 1'b0;
        end
        else if (cacop_start)
        begin
            dsel_q     <= cacop_dcache;
            cacop_i_en <= !cacop_dcache;
            cacop_d_en <= cacop_dcache;
        end
        else if ((cacop_i_en || cacop_d_en) && ready_hit)
        begin
            cacop_i_en <= 1'b0;                   // accepted, drop request
            cacop_d_en <= 1'b0;
            wait_q     <= 1'b1;
        end
        else if (cacop_finish)
            wait_q <= 1'b0;
    end

    a_one_cache: assert property (@(posedge clk) disable iff (!rstn)
        !(cacop_i_en && cacop_d_en));

endmodule

// ==== logic/priv_unit.sv ====
`timescale 1ns/1ps
module priv_unit (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       en,
    input  logic [31:0]                ins,
    input  logic [31:0]                rj_data,
    input  logic [31:0]                rk_data,
    input  logic [priv_pkg::uop_w-1:0] uop,
    output logic                       done,
    output logic [31:0]                rd_value,
    output logic [1:0]                 cacop_ins_type,
    output logic [31:0]                cacop_vaddr,
    output logic                       cacop_i_en,
    output logic                       cacop_d_en,
    input  logic                       cacop_i_ready,
    input  logic                       cacop_d_ready,
    input  logic                       cacop_i_done,
    input  logic                       cacop_d_done,
    output logic                       ertn_en,
    output logic [31:0]                ertn_pc,
    output logic [1:0]                 plv,
    input  logic                       i_idle,
    input  logic                       d_idle,
    output logic                       block_cache,
    output logic                       block_clock,
    output logic                       tlbsrch_valid,
    output logic                       tlbrd_valid,
    output logic                       tlbwr_valid,
    output logic                       tlbfill_valid,
    output logic                       invtlb_valid,
    input  logic                       tlbsrch_ready,
    input  logic                       tlbrd_ready,
    input  logic                       tlbwr_ready,
    input  logic                       tlbfill_ready,
    input  logic                       invtlb_ready,
    output logic [4:0]                 invtlb_op,
    output logic [31:0]                invtlb_asid,
    output logic [18:0]                invtlb_va
);

    logic cacop_start;
    logic cacop_dcache;
    logic cacop_finish;

    csr_bus_if csr_bus ();

    priv_ctrl ctrl_i (
        .clk(clk), .rstn(rstn), .en(en), .ins(ins),
        .rj_data(rj_data), .rk_data(rk_data), .uop(uop),
        .done(done), .rd_value(rd_value), .csr(csr_bus.ctrl), .ertn_en(ertn_en),
        .cacop_start(cacop_start), .cacop_dcache(cacop_dcache), .cacop_finish(cacop_finish),
        .i_idle(i_idle), .d_idle(d_idle), .block_cache(block_cache), .block_clock(block_clock),
        .tlbsrch_valid(tlbsrch_valid), .tlbrd_valid(tlbrd_valid), .tlbwr_valid(tlbwr_valid),
        .tlbfill_valid(tlbfill_valid), .invtlb_valid(invtlb_valid),
        .tlbsrch_ready(tlbsrch_ready), .tlbrd_ready(tlbrd_ready), .tlbwr_ready(tlbwr_ready),
        .tlbfill_ready(tlbfill_ready), .invtlb_ready(invtlb_ready)
    );

    csr_file csr_i (
        .clk(clk), .rstn(rstn), .csr(csr_bus.file),
        .ertn_en(ertn_en), .ertn_pc(ertn_pc), .plv(plv)
    );

    cacop_port cacop_i (
        .clk(clk), .rstn(rstn), .cacop_start(cacop_start), .cacop_dcache(cacop_dcache),
        .ins(ins), .rj_data(rj_data), .cacop_finish(cacop_finish),
        .cacop_ins_type(cacop_ins_type), .cacop_vaddr(cacop_vaddr),
        .cacop_i_en(cacop_i_en), .cacop_d_en(cacop_d_en),
        .cacop_i_ready(cacop_i_ready), .cacop_d_ready(cacop_d_ready),
        .cacop_i_done(cacop_i_done), .cacop_d_done(cacop_d_done)
    );

    // invtlb fields, valid alongside invtlb_valid
    assign invtlb_op   = ins[4:0];
    assign invtlb_asid = rj_data;
    assign invtlb_va   = rk_data[31:13];

endmodule

// ==== dv/priv_unit_tb.sv ====
`timescale 1ns/1ps
module priv_unit_tb;

    localparam int max_vec = 64;
    localparam logic [31:0] k_csr   = 32'd1;
    localparam logic [31:0] k_cache = 32'd2;
    localparam logic [31:0] k_ertn  = 32'd3;
    localparam logic [31:0] k_idle  = 32'd4;
    localparam logic [31:0] k_tlb   = 32'd5;

    logic clk, rstn, en, done;
    logic [31:0] ins, rj_data, rk_data, rd_value;
    logic [priv_pkg::uop_w-1:0] uop;
    logic [1:0] cacop_ins_type, plv;
    logic [31:0] cacop_vaddr, ertn_pc, invtlb_asid;
    logic cacop_i_en, cacop_d_en, cacop_i_ready, cacop_d_ready, cacop_i_done, cacop_d_done;
    logic ertn_en, i_idle, d_idle, block_cache, block_clock;
    logic tlbsrch_valid, tlbrd_valid, tlbwr_valid, tlbfill_valid, invtlb_valid;
    logic tlbsrch_ready, tlbrd_ready, tlbwr_ready, tlbfill_ready, invtlb_ready;
    logic [4:0]  invtlb_op;
    logic [18:0] invtlb_va;
    logic [4:0]  tlb_valids;

    logic [31:0] vec_mem [0:511];
    logic [31:0] m_crmd, m_prmd, m_era;
    logic [31:0] m_save [4];
    int n_vec = 0;
    int limit = 0;
    int cyc = 0;
    int value_errs = 0;
    int other_errs = 0;
    int cache_ready_cyc = -1;
    int cache_done_cyc = -1;
    int tlb_ready_cyc = -1;
    int idle_cyc = -1;
    int unsigned lcg_state = 49684;

    priv_unit dut_i (.*);

    assign tlb_valids = {invtlb_valid, tlbfill_valid, tlbwr_valid, tlbrd_valid, tlbsrch_valid};

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    // cycle counter and watchdog
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (limit > 0 && cyc >= limit)
        begin
            $display("timeout after %0d cycles, the unit stopped answering", cyc);
            $display("sim failed");
            $finish;
        end
    end

    function automatic int pick_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) % 8);        // 0 to 7 cycles
    endfunction

    function automatic logic [31:0] vec_word(input int v, input int col);
        logic [8:0] a;
        a = 9'(v * 7 + col);
        return vec_mem[a];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            value_errs++;
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        other_errs++;
        $display("ERROR %s", msg);
    endtask

    function automatic logic [31:0] model_read(input logic [csr_pkg::csr_addr_w-1:0] a);
        case (a)
            csr_pkg::csr_crmd:  return m_crmd;
            csr_pkg::csr_prmd:  return m_prmd;
            csr_pkg::csr_era:   return m_era;
            csr_pkg::csr_save0: return m_save[0];
            csr_pkg::csr_save1: return m_save[1];
            csr_pkg::csr_save2: return m_save[2];
            csr_pkg::csr_save3: return m_save[3];
            default:            return 32'h0;
        endcase
    endfunction

    task automatic model_write(input logic [csr_pkg::csr_addr_w-1:0] a, input logic [31:0] v);
        case (a)
            csr_pkg::csr_crmd:  m_crmd = v & csr_pkg::crmd_mask;
            csr_pkg::csr_prmd:  m_prmd = v & csr_pkg::prmd_mask;
            csr_pkg::csr_era:   m_era = v;
            csr_pkg::csr_save0: m_save[0] = v;
            csr_pkg::csr_save1: m_save[1] = v;
            csr_pkg::csr_save2: m_save[2] = v;
            csr_pkg::csr_save3: m_save[3] = v;
            default: ;                                 // unknown csr is dropped
        endcase
    endtask

    // invtlb marker wins over the sub-op in bits 11:10
    function automatic logic [4:0] tlb_strobe(input logic [31:0] w);
        if (w[priv_pkg::invtlb_bit])
            return 5'b10000;
        case (w[11:10])
            priv_pkg::tlb_srch: return 5'b00001;
            priv_pkg::tlb_rd:   return 5'b00010;
            priv_pkg::tlb_wr:   return 5'b00100;
            priv_pkg::tlb_fill: return 5'b01000;
            default:            return 5'b00000;
        endcase
    endfunction

    task automatic run_vector(input int idx);
        logic [31:0] kind, word, uop_word, rj, rk, exp_rd, exp_va, old_val;
        logic [4:0]  opsel;
        logic        dsel;
        int          start_cyc, done_cyc, clk_cnt, clk_cyc;
        kind     = vec_word(idx, 0);
        word     = vec_word(idx, 1);
        uop_word = vec_word(idx, 2);
        rj       = vec_word(idx, 3);
        rk       = vec_word(idx, 4);
        exp_rd   = vec_word(idx, 5);
        exp_va   = vec_word(idx, 6);
        old_val  = model_read(word[23:10]);
        dsel     = (word[2:0] == priv_pkg::cacop_tgt_d);
        opsel    = (kind == k_tlb) ? tlb_strobe(word) : 5'b00000;
        @(posedge clk);
        #1;
        en        = 1'b1;
        ins       = word;
        uop       = uop_word[priv_pkg::uop_w-1:0];
        rj_data   = rj;
        rk_data   = rk;
        start_cyc = cyc;
        @(negedge clk);
        check("done", 32'(done), 32'h0);
        check("ertn_en", 32'(ertn_en), 32'(kind == k_ertn));
        check("block_cache", 32'(block_cache), 32'(kind == k_idle));
        check("tlb valids", 32'(tlb_valids), 32'(opsel));
        if (opsel[4])
        begin
            check("invtlb_op", 32'(invtlb_op), 32'(word[4:0]));
            check("invtlb_asid", invtlb_asid, rj);
            check("invtlb_va", 32'(invtlb_va), 32'(rk[31:13]));
        end
        @(posedge clk);
        #1;
        en = 1'b0;
        @(negedge clk);
        check("ertn_en", 32'(ertn_en), 32'h0);
        check("block_clock", 32'(block_clock), 32'h0);
        if (kind == k_cache)
        begin
            check("cacop_i_en", 32'(cacop_i_en), 32'(!dsel));
            check("cacop_d_en", 32'(cacop_d_en), 32'(dsel));
            check("cacop_vaddr", cacop_vaddr, exp_va);
            check("cacop_ins_type", 32'(cacop_ins_type), 32'(word[4:3]));
        end
        clk_cnt = 0;
        clk_cyc = 0;
        while (!done)
        begin
            if (ertn_en || tlb_valids != 5'b00000)
                report_problem("a start strobe stayed high after the en cycle");
            if (kind == k_idle && !block_cache)
                report_problem("block_cache dropped before the caches went idle");
            if (cacop_i_en && cacop_d_en)
                report_problem("both cache enables high together");
            if ((cacop_i_en || cacop_d_en) && cache_ready_cyc > start_cyc && cyc > cache_ready_cyc)
                report_problem("cache enable still high after ready");
            if (block_clock)
            begin
                clk_cnt++;
                clk_cyc = cyc;
            end
            @(negedge clk);
        end
        done_cyc = cyc;
        if (kind != k_idle && clk_cnt != 0)
            report_problem($sformatf("vector %0d raised block_clock outside idle", idx));
        if (kind == k_csr)
        begin
            if (done_cyc != start_cyc + 1)
                report_problem($sformatf("vector %0d: csr done not one cycle after en", idx));
            check("rd_value", rd_value, exp_rd);
            if (old_val !== exp_rd)
                report_problem($sformatf("vector %0d expects a value the csr model disputes", idx));
            if (word[9:5] == 5'd1)
                model_write(word[23:10], rk);                                   // csrwr
            else if (word[9:5] > 5'd1)
                model_write(word[23:10], (old_val & ~rj) | (rk & rj));          // csrxchg
            @(negedge clk);
            check("plv", 32'(plv), 32'(m_crmd[1:0]));
            check("ertn_pc", ertn_pc, m_era);
        end
        else if (kind == k_ertn)
        begin
            if (done_cyc != start_cyc + 1)
                report_problem($sformatf("vector %0d: ertn done not one cycle after en", idx));
            m_crmd[2:0] = m_prmd[2:0];
            check("plv", 32'(plv), 32'(m_crmd[1:0]));
            check("ertn_pc", ertn_pc, m_era);
        end
        else if (kind == k_cache)
        begin
            if (done_cyc != cache_done_cyc + 1)
                report_problem($sformatf("vector %0d: done not one cycle after cache done", idx));
        end
        else if (kind == k_idle)
        begin
            if (clk_cnt != 1 || clk_cyc != idle_cyc + 1 || done_cyc != idle_cyc + 2)
                report_problem($sformatf("vector %0d: idle did not block the clock once", idx));
            check("block_cache", 32'(block_cache), 32'h0);
        end
        else if (done_cyc != tlb_ready_cyc + 1)
            report_problem($sformatf("vector %0d: done not one cycle after tlb ready", idx));
    endtask

    initial
    begin : cache_responder
        int   gap;
        logic dside;
        cacop_i_ready = 1'b0;
        cacop_d_ready = 1'b0;
        cacop_i_done  = 1'b0;
        cacop_d_done  = 1'b0;
        forever
        begin
            @(negedge clk);
            if (cacop_i_en || cacop_d_en)
            begin
                dside = cacop_d_en;
                gap = pick_delay();
                repeat (gap) @(posedge clk);
                @(posedge clk);
                #1;
                cacop_i_ready   = !dside;
                cacop_d_ready   = dside;
                cache_ready_cyc = cyc;
                @(posedge clk);
                #1;
                cacop_i_ready = 1'b0;
                cacop_d_ready = 1'b0;
                gap = pick_delay();
                repeat (gap) @(posedge clk);
                @(posedge clk);
                #1;
                cacop_i_done   = !dside;
                cacop_d_done   = dside;
                cache_done_cyc = cyc;
                @(posedge clk);
                #1;
                cacop_i_done = 1'b0;
                cacop_d_done = 1'b0;
            end
        end
    end

    initial
    begin : tlb_responder
        int         gap;
        logic [4:0] which;
        {invtlb_ready, tlbfill_ready, tlbwr_ready, tlbrd_ready, tlbsrch_ready} = 5'b00000;
        forever
        begin
            @(negedge clk);
            which = tlb_valids;
            if (which != 5'b00000)
            begin
                gap = pick_delay();
                repeat (gap) @(posedge clk);
                @(posedge clk);
                #1;
                {invtlb_ready, tlbfill_ready, tlbwr_ready, tlbrd_ready, tlbsrch_ready} = which;
                tlb_ready_cyc = cyc;
                @(posedge clk);
                #1;
                {invtlb_ready, tlbfill_ready, tlbwr_ready, tlbrd_ready, tlbsrch_ready} = 5'b00000;
            end
        end
    end

    // icache goes idle first, dcache some cycles later
    initial
    begin : idle_responder
        int gap;
        i_idle = 1'b0;
        d_idle = 1'b0;
        forever
        begin
            @(negedge clk);
            if (block_cache)
            begin
                gap = pick_delay();
                repeat (gap) @(posedge clk);
                @(posedge clk);
                #1;
                i_idle = 1'b1;
                gap = pick_delay();
                repeat (gap) @(posedge clk);
                @(posedge clk);
                #1;
                d_idle   = 1'b1;
                idle_cyc = cyc;
                @(posedge clk);
                #1;
                i_idle = 1'b0;
                d_idle = 1'b0;
                while (block_cache)
                    @(negedge clk);
            end
        end
    end

    initial
    begin
        en      = 1'b0;
        ins     = 32'h0;
        rj_data = 32'h0;
        rk_data = 32'h0;
        uop     = '0;
        rstn    = 1'b0;
        m_crmd  = 32'h0;
        m_prmd  = 32'h0;
        m_era   = 32'h0;
        m_save  = '{default: 32'h0};
        $readmemh("dv/priv_vectors.txt", vec_mem);
        while (n_vec < max_vec && vec_word(n_vec, 0) >= k_csr && vec_word(n_vec, 0) <= k_tlb)
            n_vec++;
        limit = n_vec * 40;
        if (n_vec == 0)
            report_problem("no vectors found in dv/priv_vectors.txt");
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int i = 0; i < n_vec; i++)
            run_vector(i);
        repeat (2) @(posedge clk);
        $display("%0d vectors, %0d value mismatches, %0d other errors",
                 n_vec, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== dv/priv_vectors.txt ====
// kind (1 csr, 2 cacop, 3 ertn, 4 idle, 5 tlb) ins uop rj rk exp_rd_value exp_cacop_vaddr
// a line with kind 0 ends the list
1 0400C004 01 00000000 00000000 00000000 00000000
1 0400C024 01 00000000 12345678 00000000 00000000
1 0400C004 01 00000000 00000000 12345678 00000000
1 0400C044 01 0000FFFF ABCDEF01 12345678 00000000
1 0400C004 01 00000000 00000000 1234EF01 00000000
1 04000024 01 00000000 FFFFFFFB 00000000 00000000
1 04000004 01 00000000 00000000 00000003 00000000
1 04000424 01 00000000 00000005 00000000 00000000
1 04001824 01 00000000 1C008000 00000000 00000000
1 0400CC44 01 FFFFFFFF CAFEF00D 00000000 00000000
1 04001C24 01 00000000 DEADBEEF 00000000 00000000
1 04001C04 01 00000000 00000000 00000000 00000000
1 0400CC04 01 00000000 00000000 CAFEF00D 00000000
3 06483800 04 00000000 00000000 00000000 00000000
1 04000004 01 00000000 00000000 00000005 00000000
2 06004008 02 00001000 00000000 00000000 00001010
2 063FE011 02 80000100 00000000 00000000 800000F8
2 061FFC01 02 00000000 00000000 00000000 000007FF
2 06200018 02 00010000 00000000 00000000 0000F800
4 06488000 08 00000000 00000000 00000000 00000000
5 06482800 10 00000000 00000000 00000000 00000000
5 06482C00 10 00000000 00000000 00000000 00000000
5 06483000 10 00000000 00000000 00000000 00000000
5 06483400 10 00000000 00000000 00000000 00000000
5 06499065 10 0000002A 12346000 00000000 00000000
4 06488000 08 00000000 00000000 00000000 00000000
0 00000000 00 00000000 00000000 00000000 00000000

// ==== filelist.f ====
logic/priv_pkg.sv
logic/csr_pkg.sv
logic/csr_bus_if.sv
logic/priv_ctrl.sv
logic/csr_file.sv
logic/cacop_port.sv
logic/priv_unit.sv
dv/priv_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the priv_unit testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f filelist.f \
    --top-module priv_unit_tb \
    -Mdir obj_dir -o priv_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/priv_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
